/* nice_bus_pkg.sv */
// host and memory bus payload types, imported by every block that touches a bus
package nice_bus_pkg;

   //////////////////////////////
   // widths
   //////////////////////////////

   // data and address width
   localparam int xlen_c = 32;

   // byte step between consecutive words
   localparam int word_bytes_c = 4;

   //////////////////////////////
   // host side
   //////////////////////////////

   // request from the host core, valid/ready handshake
   typedef struct packed {
      logic [xlen_c-1:0] inst;
      logic [xlen_c-1:0] rs1;
      // carried for completeness, no instruction reads it
      logic [xlen_c-1:0] rs2;
   } nice_req_t;

   // response back to the host core
   typedef struct packed {
      logic [xlen_c-1:0] rdat;
      logic              err;
   } nice_rsp_t;

   //////////////////////////////
   // memory side
   //////////////////////////////

   // memory command, one word per transfer
   typedef struct packed {
      logic [xlen_c-1:0] addr;
      // 1 for a read, 0 for a write
      logic              read;
      logic [xlen_c-1:0] wdata;
   } mem_cmd_t;

   // memory response, returned in command order
   typedef struct packed {
      logic [xlen_c-1:0] rdata;
      logic              err;
   } mem_rsp_t;

endpackage

/* nice_core.sv */
// top level of the custom3 coprocessor, connected to a host core and a memory bus
module nice_core
   import nice_isa_pkg::*, nice_bus_pkg::*;
#(
   parameter int ROW_WORDS = 5
) (
   input  logic      nice_clk,
   input  logic      reset,
   // host request
   input  logic      req_valid,
   output logic      req_ready,
   input  nice_req_t req,
   // host response
   output logic      rsp_valid,
   input  logic      rsp_ready,
   output nice_rsp_t rsp,
   // memory command
   output logic      mem_cmd_valid,
   input  logic      mem_cmd_ready,
   output mem_cmd_t  mem_cmd,
   // memory response, always accepted
   input  logic      mem_rsp_valid,
   input  mem_rsp_t  mem_rsp
);

   localparam int IDX_W = $clog2(ROW_WORDS);

   // decode to execute
   nice_dec_t         dec;
   // execute to row buffer
   logic [IDX_W-1:0]  rd_idx;
   logic [xlen_c-1:0] rd_data;
   logic              wr_en;
   logic              wr_acc;
   logic [IDX_W-1:0]  wr_idx;
   logic [xlen_c-1:0] wr_data;
   // execute to result
   logic              word_strobe;
   logic [xlen_c-1:0] word_data;
   logic              word_err;
   logic              word_first;
   logic              word_last;
   logic              finish;
   nice_op_e          finish_op;
   logic              rsp_done;

   //////////////////////////////
   // decode
   //////////////////////////////

   nice_decode u_decode (.req(req), .dec(dec));

   //////////////////////////////
   // execute
   //////////////////////////////

   nice_exec_ctrl #(.ROW_WORDS(ROW_WORDS)) u_exec_ctrl (
      .nice_clk, .reset, .req_valid, .req_ready, .dec,
      .mem_cmd_valid, .mem_cmd_ready, .mem_cmd, .mem_rsp_valid, .mem_rsp,
      .rd_idx, .rd_data, .wr_en, .wr_acc, .wr_idx, .wr_data,
      .word_strobe, .word_data, .word_err, .word_first, .word_last,
      .finish, .finish_op, .rsp_done
   );

   nice_row_buf #(.ROW_WORDS(ROW_WORDS)) u_row_buf (
      .nice_clk, .reset, .rd_idx, .rd_data, .wr_en, .wr_acc, .wr_idx, .wr_data
   );

   //////////////////////////////
   // result
   //////////////////////////////

   nice_result u_result (
      .nice_clk, .reset, .word_strobe, .word_data, .word_err, .word_first,
      .word_last, .finish, .finish_op, .rsp_valid, .rsp_ready, .rsp, .rsp_done
   );

endmodule

/* nice_core_chk.sv */
// protocol assertions for nice_core, attached to the core with bind from the testbench
module nice_core_chk
   import nice_bus_pkg::*;
(
   input logic      nice_clk,
   input logic      reset,
   input logic      req_valid,
   input logic      req_ready,
   input logic      rsp_valid,
   input logic      rsp_ready,
   input nice_rsp_t rsp,
   input logic      mem_cmd_valid,
   input logic      mem_cmd_ready,
   input mem_cmd_t  mem_cmd
);

   int                chk_errors = 0;
   logic              have_prev;
   logic [xlen_c-1:0] prev_addr;
   logic              req_hsk;
   logic              cmd_hsk;

   assign req_hsk = req_valid & req_ready;
   assign cmd_hsk = mem_cmd_valid & mem_cmd_ready;

   // address of the last command of the running instruction
   always_ff @(posedge nice_clk) begin
      if (reset) have_prev <= 1'b0;
      else if (cmd_hsk) have_prev <= 1'b1;
      else if (rsp_valid & rsp_ready) have_prev <= 1'b0;
   end

   always_ff @(posedge nice_clk) begin
      if (cmd_hsk) prev_addr <= mem_cmd.addr;
   end

   //////////////////////////////
   // assertions
   //////////////////////////////

   a_cmd_hold: assert property (@(posedge nice_clk) disable iff (reset)
      mem_cmd_valid && !mem_cmd_ready |=> mem_cmd_valid && $stable(mem_cmd))
      else begin
         chk_errors++;
         $error("memory command dropped or changed before its transfer");
      end

   a_rsp_hold: assert property (@(posedge nice_clk) disable iff (reset)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
      else begin
         chk_errors++;
         $error("host response dropped or changed before its transfer");
      end

   // first cycle out of reset
   a_reset_idle: assert property (@(posedge nice_clk)
      $fell(reset) |-> !mem_cmd_valid && !rsp_valid)
      else begin
         chk_errors++;
         $error("valid raised in the first cycle after reset");
      end

   // the first command rides on the request transfer
   a_addr_step: assert property (@(posedge nice_clk) disable iff (reset)
      cmd_hsk && !req_hsk && have_prev |-> mem_cmd.addr == prev_addr + xlen_c'(word_bytes_c))
      else begin
         chk_errors++;
         $error("command address does not step by one word");
      end

endmodule

/* nice_decode.sv */
// combinational decode of the host instruction, instantiated once inside nice_core
module nice_decode
   import nice_isa_pkg::*, nice_bus_pkg::*;
(
   input  nice_req_t req,
   output nice_dec_t dec
);

   // R-type fields
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = req.inst[6:0];
   assign funct3 = req.inst[14:12];
   assign funct7 = req.inst[31:25];

   //////////////////////////////
   // operation select
   //////////////////////////////

   always_comb begin
      // rs1 is the row base address for every operation
      dec.base = req.rs1;
      // anything not matched below is rejected
      dec.op   = op_illegal;
      if (opcode == opc_custom3_c) begin
         if ((funct3 == funct3_lbuf_c) && (funct7 == funct7_lbuf_c)) begin
            dec.op = op_lbuf;
         end
         else if ((funct3 == funct3_lbuf_c) && (funct7 == funct7_sbuf_c)) begin
            // sbuf shares funct3 with lbuf
            dec.op = op_sbuf;
         end
         else if ((funct3 == funct3_rowsum_c) && (funct7 == funct7_rowsum_c)) begin
            dec.op = op_rowsum;
         end
      end
   end

endmodule

/* nice_exec_ctrl.sv */
// execute control: FSM, memory command/response counters and row-buffer writes, used in nice_core
module nice_exec_ctrl
   import nice_isa_pkg::*, nice_bus_pkg::*;
#(
   parameter  int ROW_WORDS = 5,
   localparam int IDX_W     = $clog2(ROW_WORDS),
   localparam int CNT_W     = $clog2(ROW_WORDS + 1)
) (
   input  logic              nice_clk,
   input  logic              reset,
   // host request side
   input  logic              req_valid,
   output logic              req_ready,
   input  nice_dec_t         dec,
   // memory bus
   output logic              mem_cmd_valid,
   input  logic              mem_cmd_ready,
   output mem_cmd_t          mem_cmd,
   input  logic              mem_rsp_valid,
   input  mem_rsp_t          mem_rsp,
   // row buffer ports
   output logic [IDX_W-1:0]  rd_idx,
   input  logic [xlen_c-1:0] rd_data,
   output logic              wr_en,
   output logic              wr_acc,
   output logic [IDX_W-1:0]  wr_idx,
   output logic [xlen_c-1:0] wr_data,
   // result stage
   output logic              word_strobe,
   output logic [xlen_c-1:0] word_data,
   output logic              word_err,
   output logic              word_first,
   output logic              word_last,
   output logic              finish,
   output nice_op_e          finish_op,
   input  logic              rsp_done
);

   typedef enum logic [2:0] {
      st_idle, st_lbuf, st_sbuf, st_rowsum, st_wait_rsp
   } state_e;

   state_e            state_r;
   state_e            state_nxt;
   logic [CNT_W-1:0]  cmd_cnt_r;
   logic [IDX_W-1:0]  rsp_cnt_r;
   logic [xlen_c-1:0] addr_r;
   logic              st_is_idle;
   logic              st_is_busy;
   logic              dec_legal;
   logic              req_hsk;
   logic              cmd_hsk;
   logic              rsp_hsk;
   logic              rsp_last;

   assign st_is_idle = (state_r == st_idle);
   assign st_is_busy = (state_r == st_lbuf) || (state_r == st_sbuf) || (state_r == st_rowsum);
   assign dec_legal  = (dec.op != op_illegal);

   //////////////////////////////
   // handshakes
   //////////////////////////////

   // legal ops issue the first command together with the request
   assign req_ready = st_is_idle & (~dec_legal | mem_cmd_ready);
   assign req_hsk   = req_valid & req_ready;
   assign cmd_hsk   = mem_cmd_valid & mem_cmd_ready;
   // memory responses are always taken
   assign rsp_hsk   = st_is_busy & mem_rsp_valid;
   assign rsp_last  = rsp_hsk & (rsp_cnt_r == IDX_W'(ROW_WORDS - 1));

   //////////////////////////////
   // FSM
   //////////////////////////////

   always_comb begin
      state_nxt = state_r;
      case (state_r)
         st_idle: begin
            if (req_hsk) begin
               case (dec.op)
                  op_lbuf:   state_nxt = st_lbuf;
                  op_sbuf:   state_nxt = st_sbuf;
                  op_rowsum: state_nxt = st_rowsum;
                  default:   state_nxt = st_wait_rsp;
               endcase
            end
         end
         st_lbuf, st_sbuf, st_rowsum: begin
            if (rsp_last) state_nxt = st_wait_rsp;
         end
         default: begin
            // hold until the host takes the response
            if (rsp_done) state_nxt = st_idle;
         end
      endcase
   end

   always_ff @(posedge nice_clk) begin
      if (reset) state_r <= st_idle;
      else state_r <= state_nxt;
   end

   // counters come back to zero at the last response
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         cmd_cnt_r <= '0;
         rsp_cnt_r <= '0;
      end
      else begin
         if (req_hsk & dec_legal) cmd_cnt_r <= CNT_W'(1);
         else if (rsp_last) cmd_cnt_r <= '0;
         else if (cmd_hsk) cmd_cnt_r <= cmd_cnt_r + 1'b1;
         if (rsp_last) rsp_cnt_r <= '0;
         else if (rsp_hsk) rsp_cnt_r <= rsp_cnt_r + 1'b1;
      end
   end

   // next word address, stepped on every command transfer
   always_ff @(posedge nice_clk) begin
      if (cmd_hsk) addr_r <= mem_cmd.addr + xlen_c'(word_bytes_c);
   end

   //////////////////////////////
   // memory command
   //////////////////////////////

   assign mem_cmd_valid = st_is_idle ? (req_valid & dec_legal)
                                     : (st_is_busy & (cmd_cnt_r < CNT_W'(ROW_WORDS)));
   assign mem_cmd.addr  = st_is_idle ? dec.base : addr_r;
   assign mem_cmd.read  = st_is_idle ? (dec.op != op_sbuf) : (state_r != st_sbuf);
   // sbuf data from the row buffer, zero on reads
   assign rd_idx        = cmd_cnt_r[IDX_W-1:0];
   assign mem_cmd.wdata = mem_cmd.read ? '0 : rd_data;

   // lbuf overwrites, rowsum adds in, sbuf leaves the row alone
   assign wr_en   = rsp_hsk & (state_r != st_sbuf);
   assign wr_acc  = (state_r == st_rowsum);
   assign wr_idx  = rsp_cnt_r;
   assign wr_data = mem_rsp.rdata;

   //////////////////////////////
   // result stage feed
   //////////////////////////////

   assign word_strobe = rsp_hsk;
   assign word_data   = mem_rsp.rdata;
   assign word_err    = mem_rsp.err;
   assign word_first  = (rsp_cnt_r == '0);
   assign word_last   = (rsp_cnt_r == IDX_W'(ROW_WORDS - 1));

   // rowsum answers from the accumulator, not from finish
   assign finish = (req_hsk & ~dec_legal) | (rsp_last & (state_r != st_rowsum));

   always_comb begin
      case (state_r)
         st_lbuf: finish_op = op_lbuf;
         st_sbuf: finish_op = op_sbuf;
         default: finish_op = op_illegal;
      endcase
   end

endmodule

/* nice_isa_pkg.sv */
// custom3 instruction encodings and decoded-instruction types, imported by decode and execute
package nice_isa_pkg;

   //////////////////////////////
   // opcode and function fields
   //////////////////////////////

   // only the custom3 space is used, R-type format
   localparam logic [6:0] opc_custom3_c = 7'b1111011;

   // lbuf and sbuf share funct3, funct7 tells them apart
   localparam logic [2:0] funct3_lbuf_c   = 3'b010;
   localparam logic [2:0] funct3_rowsum_c = 3'b110;

   localparam logic [6:0] funct7_lbuf_c   = 7'b0000001;
   localparam logic [6:0] funct7_sbuf_c   = 7'b0000010;
   localparam logic [6:0] funct7_rowsum_c = 7'b0000110;

   //////////////////////////////
   // decoded operation
   //////////////////////////////

   // op_illegal covers every encoding outside the three above
   typedef enum logic [1:0] {
      op_lbuf    = 2'd0,
      op_sbuf    = 2'd1,
      op_rowsum  = 2'd2,
      op_illegal = 2'd3
   } nice_op_e;

   // decode result handed to the execute stage
   typedef struct packed {
      // operation selected from opcode, funct3, funct7
      nice_op_e    op;
      // rs1, first word address of the row
      logic [31:0] base;
   } nice_dec_t;

endpackage

/* nice_result.sv */
// result stage: receive buffer, rowsum accumulator, sticky error and host response register
module nice_result
   import nice_isa_pkg::*, nice_bus_pkg::*;
(
   input  logic              nice_clk,
   input  logic              reset,
   // per-word feed from execute
   input  logic              word_strobe,
   input  logic [xlen_c-1:0] word_data,
   input  logic              word_err,
   input  logic              word_first,
   input  logic              word_last,
   input  logic              finish,
   input  nice_op_e          finish_op,
   // host response
   output logic              rsp_valid,
   input  logic              rsp_ready,
   output nice_rsp_t         rsp,
   output logic              rsp_done
);

   logic              rcv_valid_r;
   logic              rcv_first_r;
   logic              rcv_last_r;
   logic [xlen_c-1:0] rcv_data_r;
   logic [xlen_c-1:0] acc_r;
   logic [xlen_c-1:0] acc_nxt;
   logic              err_r;
   logic              err_now;
   logic              rcv_fin;

   //////////////////////////////
   // receive buffer
   //////////////////////////////

   // lbuf/sbuf close with finish on the last word, so only rowsum marks it
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         rcv_valid_r <= 1'b0;
         rcv_first_r <= 1'b0;
         rcv_last_r  <= 1'b0;
      end
      else begin
         rcv_valid_r <= word_strobe;
         rcv_first_r <= word_first;
         rcv_last_r  <= word_last & ~finish;
      end
   end

   always_ff @(posedge nice_clk) begin
      if (word_strobe) rcv_data_r <= word_data;
   end

   // first word loads, the rest add
   assign acc_nxt = rcv_first_r ? rcv_data_r : (acc_r + rcv_data_r);
   assign rcv_fin = rcv_valid_r & rcv_last_r;

   always_ff @(posedge nice_clk) begin
      if (rcv_valid_r) acc_r <= acc_nxt;
   end

   //////////////////////////////
   // sticky error
   //////////////////////////////

   // error of this instruction including the word arriving now
   assign err_now = word_strobe & (word_first ? word_err : (err_r | word_err))
                    | ~word_strobe & err_r;

   always_ff @(posedge nice_clk) begin
      if (reset) err_r <= 1'b0;
      else if (word_strobe) err_r <= word_first ? word_err : (err_r | word_err);
   end

   //////////////////////////////
   // response register
   //////////////////////////////

   assign rsp_done = rsp_valid & rsp_ready;

   always_ff @(posedge nice_clk) begin
      if (reset) rsp_valid <= 1'b0;
      else if (finish | rcv_fin) rsp_valid <= 1'b1;
      else if (rsp_done) rsp_valid <= 1'b0;
   end

   // payload held under back-pressure, only loads at the end of an op
   always_ff @(posedge nice_clk) begin
      if (finish) begin
         rsp.rdat <= '0;
         rsp.err  <= (finish_op == op_illegal) | err_now;
      end
      else if (rcv_fin) begin
         rsp.rdat <= acc_nxt;
         rsp.err  <= err_r;
      end
   end

endmodule

/* nice_row_buf.sv */
// row buffer register file with one read port and an overwrite-or-add write port, used in nice_core
module nice_row_buf
   import nice_bus_pkg::*;
#(
   parameter  int ROW_WORDS = 5,
   localparam int IDX_W     = $clog2(ROW_WORDS)
) (
   input  logic              nice_clk,
   input  logic              reset,
   // same-cycle read port
   input  logic [IDX_W-1:0]  rd_idx,
   output logic [xlen_c-1:0] rd_data,
   // write port takes effect at the next edge
   input  logic              wr_en,
   input  logic              wr_acc,
   input  logic [IDX_W-1:0]  wr_idx,
   input  logic [xlen_c-1:0] wr_data
);

   logic [xlen_c-1:0] rows_r [ROW_WORDS];

   //////////////////////////////
   // write port
   //////////////////////////////

   // accumulate wraps modulo 2^32
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         for (int i = 0; i < ROW_WORDS; i++) begin
            rows_r[i] <= '0;
         end
      end
      else if (wr_en) begin
         if (wr_acc) rows_r[wr_idx] <= rows_r[wr_idx] + wr_data;
         else rows_r[wr_idx] <= wr_data;
      end
   end

   //////////////////////////////
   // read port
   //////////////////////////////

   // indexes past the row read as zero
   always_comb begin
      if (int'(rd_idx) < ROW_WORDS) rd_data = rows_r[rd_idx];
      else rd_data = '0;
   end

endmodule

/* sources.f */
nice_isa_pkg.sv
nice_bus_pkg.sv
nice_decode.sv
nice_row_buf.sv
nice_exec_ctrl.sv
nice_result.sv
nice_core.sv
nice_core_chk.sv
tb_nice_mem.sv
tb_nice_core.sv

/* tb_nice_core.sv */
// testbench top for nice_core: runs host instructions against a reference row and memory shadow
module tb_nice_core
   import nice_isa_pkg::*, nice_bus_pkg::*;
();

   localparam int ROW_WORDS     = 5;
   localparam int CLK_PERIOD    = 20;
   localparam int NUM_ROUNDS    = 16;
   // fixed directed ops plus the random rounds
   localparam int NUM_OPS       = 8 + NUM_ROUNDS;
   localparam int CYCLES_PER_OP = 400;

   logic      nice_clk = 1'b0;
   logic      reset;
   logic      req_valid;
   logic      req_ready;
   nice_req_t req;
   logic      rsp_valid;
   logic      rsp_ready;
   nice_rsp_t rsp;
   logic      mem_cmd_valid;
   logic      mem_cmd_ready;
   mem_cmd_t  mem_cmd;
   logic      mem_rsp_valid;
   mem_rsp_t  mem_rsp;
   logic      stall_en;
   logic      inject_err;

   logic [31:0]       lfsr_state = 32'hda61_40a2;
   // expected row buffer and memory contents
   logic [xlen_c-1:0] ref_row [ROW_WORDS];
   logic [xlen_c-1:0] shadow [256];
   int                cmd_total = 0;

   always #(CLK_PERIOD / 2) nice_clk = ~nice_clk;

   nice_core #(.ROW_WORDS(ROW_WORDS)) u_nice_core (
      .nice_clk, .reset, .req_valid, .req_ready, .req, .rsp_valid, .rsp_ready, .rsp,
      .mem_cmd_valid, .mem_cmd_ready, .mem_cmd, .mem_rsp_valid, .mem_rsp
   );

   tb_nice_mem u_mem (
      .nice_clk, .stall_en, .inject_err, .mem_cmd_valid, .mem_cmd_ready, .mem_cmd,
      .mem_rsp_valid, .mem_rsp
   );

   bind nice_core nice_core_chk u_chk (
      .nice_clk, .reset, .req_valid, .req_ready, .rsp_valid, .rsp_ready, .rsp,
      .mem_cmd_valid, .mem_cmd_ready, .mem_cmd
   );

   //////////////////////////////
   // helpers
   //////////////////////////////

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val = {val[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      end
      return val;
   endfunction

   function automatic logic [31:0] rand_addr();
      logic [31:0] r;
      r = rand_bits(30);
      return {r[29:0], 2'b00};
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      assert (got === exp) else begin
         $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
         $display("Test failures found");
         $fatal(1, "data check failed");
      end
   endtask

   // one instruction from request to response, checked against the reference model
   task automatic run_op(input nice_op_e op, input logic [31:0] addr);
      logic [31:0]       inst;
      logic [31:0]       r;
      logic [xlen_c-1:0] exp_rdat;
      logic [7:0]        j;
      logic              exp_err;
      int                errs_before;
      int                cmds_before;
      nice_rsp_t         got;
      case (op)
         op_lbuf:   inst = {funct7_lbuf_c, 5'd12, 5'd10, funct3_lbuf_c, 5'd11, opc_custom3_c};
         op_sbuf:   inst = {funct7_sbuf_c, 5'd12, 5'd10, funct3_lbuf_c, 5'd11, opc_custom3_c};
         op_rowsum: inst = {funct7_rowsum_c, 5'd12, 5'd10, funct3_rowsum_c, 5'd11, opc_custom3_c};
         default: begin
            // plain OP opcode, outside custom3
            r = rand_bits(25);
            inst = {r[24:0], 7'b0110011};
         end
      endcase
      exp_rdat = '0;
      for (int i = 0; i < ROW_WORDS; i++) begin
         j = addr[9:2] + 8'(i);
         case (op)
            op_lbuf: ref_row[i] = shadow[j];
            op_sbuf: shadow[j] = ref_row[i];
            op_rowsum: begin
               exp_rdat = exp_rdat + shadow[j];
               ref_row[i] = ref_row[i] + shadow[j];
            end
            default: ;
         endcase
      end
      errs_before = u_mem.err_count;
      cmds_before = cmd_total;
      @(negedge nice_clk);
      req_valid = 1'b1;
      req.inst  = inst;
      req.rs1   = addr;
      req.rs2   = rand_bits(32);
      do @(posedge nice_clk); while (!req_ready);
      @(negedge nice_clk);
      req_valid = 1'b0;
      rsp_ready = stall_en ? (rand_bits(2) != 2'b00) : 1'b1;
      @(posedge nice_clk);
      while (!(rsp_valid && rsp_ready)) begin
         @(negedge nice_clk);
         rsp_ready = stall_en ? (rand_bits(2) != 2'b00) : 1'b1;
         @(posedge nice_clk);
      end
      got = rsp;
      exp_err = (op == op_illegal) || (u_mem.err_count != errs_before);
      check_value(got.rdat, exp_rdat, "response data");
      check_value(got.err, exp_err, "response error flag");
      if (op == op_illegal) check_value(cmd_total, cmds_before, "memory command count");
      if (op == op_sbuf) begin
         for (int i = 0; i < ROW_WORDS; i++) begin
            j = addr[9:2] + 8'(i);
            check_value(u_mem.mem[j], shadow[j], "stored word");
         end
      end
   endtask

   always @(posedge nice_clk) begin
      if (mem_cmd_valid && mem_cmd_ready) cmd_total <= cmd_total + 1;
   end

   always @(negedge nice_clk) begin
      if (u_nice_core.u_chk.chk_errors != 0) begin
         $display("a protocol assertion on nice_core failed");
         $display("Test failures found");
         $fatal(1, "protocol check failed");
      end
   end

   //////////////////////////////
   // watchdog
   //////////////////////////////

   initial begin
      #(CLK_PERIOD * (CYCLES_PER_OP * NUM_OPS + 10));
      $display("watchdog timeout, the DUT stopped answering instructions");
      $display("Test failures found");
      $fatal(1, "timeout");
   end

   //////////////////////////////
   // main sequence
   //////////////////////////////

   initial begin
      reset      = 1'b1;
      req_valid  = 1'b0;
      req        = '0;
      rsp_ready  = 1'b0;
      stall_en   = 1'b0;
      inject_err = 1'b0;
      repeat (3) @(posedge nice_clk);
      @(negedge nice_clk);
      reset = 1'b0;
      // memory was filled at time zero, row buffer comes out of reset cleared
      for (int i = 0; i < 256; i++) shadow[i] = u_mem.mem[i];
      for (int i = 0; i < ROW_WORDS; i++) ref_row[i] = '0;
      // copy a row, then sum one into it and store it
      run_op(op_lbuf, rand_addr());
      run_op(op_sbuf, rand_addr());
      run_op(op_rowsum, rand_addr());
      run_op(op_sbuf, rand_addr());
      run_op(op_illegal, rand_addr());
      // injected errors, then a clean op
      inject_err = 1'b1;
      run_op(op_rowsum, rand_addr());
      run_op(op_lbuf, rand_addr());
      inject_err = 1'b0;
      run_op(op_sbuf, rand_addr());
      // back-pressure on both sides with random ops
      stall_en = 1'b1;
      for (int r = 0; r < NUM_ROUNDS; r++) begin
         inject_err = (r % 4 == 1);
         run_op(nice_op_e'(rand_bits(2)), rand_addr());
      end
      if (u_nice_core.u_chk.chk_errors == 0) begin
         $display("All tests passed!");
         $finish;
      end
      else begin
         $display("Test failures found");
         $fatal(1, "protocol assertions failed");
      end
   end

endmodule

/* tb_nice_mem.sv */
// memory model for the testbench: word array with random stalls, in-order delayed responses and errors
module tb_nice_mem
   import nice_bus_pkg::*;
(
   input  logic     nice_clk,
   input  logic     stall_en,
   input  logic     inject_err,
   input  logic     mem_cmd_valid,
   output logic     mem_cmd_ready,
   input  mem_cmd_t mem_cmd,
   output logic     mem_rsp_valid,
   output mem_rsp_t mem_rsp
);

   // 1 KiB window, word index from address bits 9:2
   logic [xlen_c-1:0] mem [256];
   mem_rsp_t          rsp_q [$];
   int                wait_cnt = 0;
   int                err_count = 0;

   initial begin
      mem_cmd_ready = 1'b0;
      mem_rsp_valid = 1'b0;
      mem_rsp       = '0;
      for (int i = 0; i < 256; i++) mem[i] = tb_nice_core.rand_bits(32);
   end

   // command side, a presented response is always taken by the core
   always @(posedge nice_clk) begin : cmd_side
      mem_rsp_t rsp_new;
      if (mem_rsp_valid) void'(rsp_q.pop_front());
      if (mem_cmd_valid && mem_cmd_ready) begin
         rsp_new.err = inject_err && tb_nice_core.rand_bits(1);
         if (rsp_new.err) err_count++;
         if (mem_cmd.read) rsp_new.rdata = mem[mem_cmd.addr[9:2]];
         else begin
            mem[mem_cmd.addr[9:2]] = mem_cmd.wdata;
            rsp_new.rdata = '0;
         end
         rsp_q.push_back(rsp_new);
      end
   end

   // ready stalls and response gaps
   always @(negedge nice_clk) begin
      mem_cmd_ready = !stall_en || (tb_nice_core.rand_bits(2) != 2'b00);
      mem_rsp_valid = 1'b0;
      if (wait_cnt > 0) wait_cnt--;
      else if (rsp_q.size() > 0) begin
         mem_rsp_valid = 1'b1;
         mem_rsp       = rsp_q[0];
         wait_cnt      = tb_nice_core.rand_bits(2);
      end
   end

endmodule
